//--- design/ctrlPkg.sv
package ctrlPkg;

	// instruction fields
	localparam int opcodeWidth = 6;
	localparam int functWidth = 6;
	localparam int shamtWidth = 5;

	localparam logic [opcodeWidth-1:0] opRType = 6'h00;
	localparam logic [opcodeWidth-1:0] opBeq = 6'h04;
	localparam logic [opcodeWidth-1:0] opBne = 6'h05;
	localparam logic [opcodeWidth-1:0] opLw = 6'h23;
	localparam logic [opcodeWidth-1:0] opSw = 6'h2b;
	localparam logic [opcodeWidth-1:0] opLui = 6'h0f;
	localparam logic [opcodeWidth-1:0] opJ = 6'h02;
	localparam logic [opcodeWidth-1:0] opJal = 6'h03;
	localparam logic [opcodeWidth-1:0] opAddi = 6'h08;
	localparam logic [opcodeWidth-1:0] opAddiu = 6'h09;
	localparam logic [opcodeWidth-1:0] opAndi = 6'h0c;

	localparam logic [functWidth-1:0] fnAdd = 6'h20;
	localparam logic [functWidth-1:0] fnAnd = 6'h24;
	localparam logic [functWidth-1:0] fnSub = 6'h22;
	localparam logic [functWidth-1:0] fnXor = 6'h26;
	localparam logic [functWidth-1:0] fnBreak = 6'h0d;
	localparam logic [functWidth-1:0] fnSll = 6'h00;
	localparam logic [functWidth-1:0] fnSllv = 6'h04;
	localparam logic [functWidth-1:0] fnSra = 6'h03;
	localparam logic [functWidth-1:0] fnSrav = 6'h07;
	localparam logic [functWidth-1:0] fnSrl = 6'h02;
	localparam logic [functWidth-1:0] fnJr = 6'h08;
	localparam logic [functWidth-1:0] fnSlt = 6'h2a;

	// instruction classes
	localparam int classWidth = 4;
	localparam logic [classWidth-1:0] clsNop = 4'd0;
	localparam logic [classWidth-1:0] clsAluReg = 4'd1;
	localparam logic [classWidth-1:0] clsBreak = 4'd2;
	localparam logic [classWidth-1:0] clsBranchEq = 4'd3;
	localparam logic [classWidth-1:0] clsBranchNe = 4'd4;
	localparam logic [classWidth-1:0] clsLoad = 4'd5;
	localparam logic [classWidth-1:0] clsStore = 4'd6;
	localparam logic [classWidth-1:0] clsLui = 4'd7;
	localparam logic [classWidth-1:0] clsJump = 4'd8;
	localparam logic [classWidth-1:0] clsJumpReg = 4'd9;
	localparam logic [classWidth-1:0] clsJal = 4'd10;
	localparam logic [classWidth-1:0] clsAluImm = 4'd11;
	localparam logic [classWidth-1:0] clsShift = 4'd12;
	localparam logic [classWidth-1:0] clsSlt = 4'd13;

	// shift kind, or alu kind for clsAluReg and clsAluImm
	localparam int shiftKindWidth = 3;
	localparam logic [shiftKindWidth-1:0] skSll = 3'd0;
	localparam logic [shiftKindWidth-1:0] skSllv = 3'd1;
	localparam logic [shiftKindWidth-1:0] skSra = 3'd2;
	localparam logic [shiftKindWidth-1:0] skSrav = 3'd3;
	localparam logic [shiftKindWidth-1:0] skSrl = 3'd4;
	localparam logic [shiftKindWidth-1:0] akAdd = 3'd0;
	localparam logic [shiftKindWidth-1:0] akAnd = 3'd1;
	localparam logic [shiftKindWidth-1:0] akSub = 3'd2;
	localparam logic [shiftKindWidth-1:0] akXor = 3'd3;

	localparam int stepWidth = 4;
	localparam logic [stepWidth-1:0] stReset = 4'd0;
	localparam logic [stepWidth-1:0] stFetch = 4'd1;
	localparam logic [stepWidth-1:0] stFetchWait = 4'd2;
	localparam logic [stepWidth-1:0] stIrWrite = 4'd3;
	localparam logic [stepWidth-1:0] stDecode = 4'd4;
	localparam logic [stepWidth-1:0] stExec0 = 4'd5;
	localparam logic [stepWidth-1:0] stExec1 = 4'd6;
	localparam logic [stepWidth-1:0] stExec2 = 4'd7;
	localparam logic [stepWidth-1:0] stExec3 = 4'd8;
	localparam logic [stepWidth-1:0] stExec4 = 4'd9;

	// cycles spent after decode
	localparam logic [stepWidth-1:0] execLenNop = 4'd1;
	localparam logic [stepWidth-1:0] execLenAlu = 4'd2;
	localparam logic [stepWidth-1:0] execLenBranch = 4'd1;
	localparam logic [stepWidth-1:0] execLenLoad = 4'd5;
	localparam logic [stepWidth-1:0] execLenStore = 4'd3;
	localparam logic [stepWidth-1:0] execLenLui = 4'd1;
	localparam logic [stepWidth-1:0] execLenJump = 4'd1;
	localparam logic [stepWidth-1:0] execLenJal = 4'd2;
	localparam logic [stepWidth-1:0] execLenAluImm = 4'd2;
	localparam logic [stepWidth-1:0] execLenShift = 4'd2;
	localparam logic [stepWidth-1:0] execLenSlt = 4'd2;

	localparam int aluControlWidth = 3;
	localparam logic [aluControlWidth-1:0] aluPass = 3'b000;
	localparam logic [aluControlWidth-1:0] aluAdd = 3'b001;
	localparam logic [aluControlWidth-1:0] aluSub = 3'b010;
	localparam logic [aluControlWidth-1:0] aluAnd = 3'b011;
	localparam logic [aluControlWidth-1:0] aluXor = 3'b110;
	localparam logic [aluControlWidth-1:0] aluSlt = 3'b111;

	localparam int memToRegWidth = 3;
	localparam logic [memToRegWidth-1:0] mtrAluOut = 3'b000;
	localparam logic [memToRegWidth-1:0] mtrMdr = 3'b001;
	localparam logic [memToRegWidth-1:0] mtrImm = 3'b010;
	localparam logic [memToRegWidth-1:0] mtrZero = 3'b011;
	localparam logic [memToRegWidth-1:0] mtrOne = 3'b100;
	localparam logic [memToRegWidth-1:0] mtrShifter = 3'b101;
	localparam logic [memToRegWidth-1:0] mtrPc = 3'b110;

	localparam int origPCWidth = 3;
	localparam logic [origPCWidth-1:0] pcSeq = 3'b000;
	localparam logic [origPCWidth-1:0] pcBranch = 3'b001;
	localparam logic [origPCWidth-1:0] pcJump = 3'b010;
	localparam logic [origPCWidth-1:0] pcReg = 3'b011;

	localparam int regDstWidth = 2;
	localparam logic [regDstWidth-1:0] rdRt = 2'b00;
	localparam logic [regDstWidth-1:0] rdRd = 2'b01;
	localparam logic [regDstWidth-1:0] rdRa = 2'b10;

	localparam int shiftControlWidth = 3;
	localparam logic [shiftControlWidth-1:0] shNone = 3'b000;
	localparam logic [shiftControlWidth-1:0] shLoad = 3'b001;
	localparam logic [shiftControlWidth-1:0] shLeft = 3'b010;
	localparam logic [shiftControlWidth-1:0] shRightLogic = 3'b011;
	localparam logic [shiftControlWidth-1:0] shRightArith = 3'b100;

	localparam int aluSrcBWidth = 2;
	localparam logic [aluSrcBWidth-1:0] srcBReg = 2'b00;
	localparam logic [aluSrcBWidth-1:0] srcBFour = 2'b01;
	localparam logic [aluSrcBWidth-1:0] srcBImm = 2'b10;
	localparam logic [aluSrcBWidth-1:0] srcBImmShift = 2'b11; // branch offset

	localparam int iorDWidth = 2;
	localparam logic [iorDWidth-1:0] iodPc = 2'b00;
	localparam logic [iorDWidth-1:0] iodAluOut = 2'b01;

endpackage

//--- design/instrDecoder.sv
`timescale 1ns/10ps

module instrDecoder
(
	input logic [ctrlPkg::opcodeWidth-1:0] opcode,
	input logic [ctrlPkg::functWidth-1:0] funct,
	input logic [ctrlPkg::shamtWidth-1:0] shamt,
	output logic [ctrlPkg::classWidth-1:0] opClass,
	output logic [ctrlPkg::shiftKindWidth-1:0] opKind
);

	always_comb
	begin
		opClass = ctrlPkg::clsNop; // unknown codes behave as nop
		opKind = ctrlPkg::akAdd;
		case (opcode)
			ctrlPkg::opRType:
			begin
				case (funct)
					ctrlPkg::fnAdd: opClass = ctrlPkg::clsAluReg;
					ctrlPkg::fnAnd:
					begin
						opClass = ctrlPkg::clsAluReg;
						opKind = ctrlPkg::akAnd;
					end
					ctrlPkg::fnSub:
					begin
						opClass = ctrlPkg::clsAluReg;
						opKind = ctrlPkg::akSub;
					end
					ctrlPkg::fnXor:
					begin
						opClass = ctrlPkg::clsAluReg;
						opKind = ctrlPkg::akXor;
					end
					ctrlPkg::fnBreak: opClass = ctrlPkg::clsBreak;
					ctrlPkg::fnSll:
					begin
						// sll $0,$0,0 is the canonical nop
						if (shamt != '0)
							opClass = ctrlPkg::clsShift;
						opKind = ctrlPkg::skSll;
					end
					ctrlPkg::fnSllv:
					begin
						opClass = ctrlPkg::clsShift;
						opKind = ctrlPkg::skSllv;
					end
					ctrlPkg::fnSra:
					begin
						opClass = ctrlPkg::clsShift;
						opKind = ctrlPkg::skSra;
					end
					ctrlPkg::fnSrav:
					begin
						opClass = ctrlPkg::clsShift;
						opKind = ctrlPkg::skSrav;
					end
					ctrlPkg::fnSrl:
					begin
						opClass = ctrlPkg::clsShift;
						opKind = ctrlPkg::skSrl;
					end
					ctrlPkg::fnJr: opClass = ctrlPkg::clsJumpReg;
					ctrlPkg::fnSlt: opClass = ctrlPkg::clsSlt;
					default: opClass = ctrlPkg::clsNop;
				endcase
			end
			ctrlPkg::opBeq: opClass = ctrlPkg::clsBranchEq;
			ctrlPkg::opBne: opClass = ctrlPkg::clsBranchNe;
			ctrlPkg::opLw: opClass = ctrlPkg::clsLoad;
			ctrlPkg::opSw: opClass = ctrlPkg::clsStore;
			ctrlPkg::opLui: opClass = ctrlPkg::clsLui;
			ctrlPkg::opJ: opClass = ctrlPkg::clsJump;
			ctrlPkg::opJal: opClass = ctrlPkg::clsJal;
			ctrlPkg::opAddi, ctrlPkg::opAddiu: opClass = ctrlPkg::clsAluImm; // no overflow trap
			ctrlPkg::opAndi:
			begin
				opClass = ctrlPkg::clsAluImm;
				opKind = ctrlPkg::akAnd;
			end
			default: opClass = ctrlPkg::clsNop;
		endcase
	end

endmodule

//--- design/stepSequencer.sv
`timescale 1ns/10ps

module stepSequencer
(
	input logic clk,
	input logic reset,
	input logic [ctrlPkg::classWidth-1:0] opClass,
	output logic [ctrlPkg::stepWidth-1:0] step
);

	logic [ctrlPkg::stepWidth-1:0] execLen;
	logic [ctrlPkg::stepWidth-1:0] lastStep;
	logic [ctrlPkg::stepWidth-1:0] nextStep;

	always_comb
	begin
		case (opClass)
			ctrlPkg::clsAluReg: execLen = ctrlPkg::execLenAlu;
			ctrlPkg::clsBranchEq, ctrlPkg::clsBranchNe: execLen = ctrlPkg::execLenBranch;
			ctrlPkg::clsLoad: execLen = ctrlPkg::execLenLoad;
			ctrlPkg::clsStore: execLen = ctrlPkg::execLenStore;
			ctrlPkg::clsLui: execLen = ctrlPkg::execLenLui;
			ctrlPkg::clsJump, ctrlPkg::clsJumpReg: execLen = ctrlPkg::execLenJump;
			ctrlPkg::clsJal: execLen = ctrlPkg::execLenJal;
			ctrlPkg::clsAluImm: execLen = ctrlPkg::execLenAluImm;
			ctrlPkg::clsShift: execLen = ctrlPkg::execLenShift;
			ctrlPkg::clsSlt: execLen = ctrlPkg::execLenSlt;
			default: execLen = ctrlPkg::execLenNop; // nop, break and unknown
		endcase
	end

	assign lastStep = ctrlPkg::stExec0 + execLen - ctrlPkg::stepWidth'(1);

	always_comb
	begin
		case (step)
			ctrlPkg::stReset: nextStep = ctrlPkg::stFetch;
			ctrlPkg::stFetch: nextStep = ctrlPkg::stFetchWait;
			ctrlPkg::stFetchWait: nextStep = ctrlPkg::stIrWrite;
			ctrlPkg::stIrWrite: nextStep = ctrlPkg::stDecode;
			ctrlPkg::stDecode: nextStep = ctrlPkg::stExec0;
			default:
			begin
				if (opClass == ctrlPkg::clsBreak)
					nextStep = step; // halt until reset
				else if (step >= lastStep)
					nextStep = ctrlPkg::stFetch;
				else
					nextStep = step + ctrlPkg::stepWidth'(1);
			end
		endcase
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			step <= ctrlPkg::stReset;
		else
			step <= nextStep;
	end

endmodule

//--- design/controlEncoder.sv
`timescale 1ns/10ps

module controlEncoder
(
	input logic [ctrlPkg::classWidth-1:0] opClass,
	input logic [ctrlPkg::shiftKindWidth-1:0] opKind,
	input logic [ctrlPkg::stepWidth-1:0] step,
	input logic menor,
	output logic memWriteOrRead,
	output logic mdrControl,
	output logic pcControl,
	output logic pcCond,
	output logic [ctrlPkg::origPCWidth-1:0] origPC,
	output logic bneORbeq,
	output logic irWrite,
	output logic writeA,
	output logic writeB,
	output logic regWrite,
	output logic aluSrcA,
	output logic [ctrlPkg::aluSrcBWidth-1:0] aluSrcB,
	output logic [ctrlPkg::aluControlWidth-1:0] aluControl,
	output logic regAluControl,
	output logic [ctrlPkg::regDstWidth-1:0] regDst,
	output logic [ctrlPkg::memToRegWidth-1:0] memToReg,
	output logic [ctrlPkg::shiftControlWidth-1:0] shiftControl,
	output logic [ctrlPkg::iorDWidth-1:0] IorD,
	output logic shamtOrRs
);

	logic [ctrlPkg::aluControlWidth-1:0] kindAluOp;

	always_comb
	begin
		case (opKind)
			ctrlPkg::akAnd: kindAluOp = ctrlPkg::aluAnd;
			ctrlPkg::akSub: kindAluOp = ctrlPkg::aluSub;
			ctrlPkg::akXor: kindAluOp = ctrlPkg::aluXor;
			default: kindAluOp = ctrlPkg::aluAdd;
		endcase
	end

	always_comb
	begin
		memWriteOrRead = 1'b0;
		mdrControl = 1'b0;
		pcControl = 1'b0;
		pcCond = 1'b0;
		origPC = ctrlPkg::pcSeq;
		bneORbeq = 1'b0;
		irWrite = 1'b0;
		writeA = 1'b0;
		writeB = 1'b0;
		regWrite = 1'b0;
		aluSrcA = 1'b0;
		aluSrcB = ctrlPkg::srcBReg;
		aluControl = ctrlPkg::aluPass;
		regAluControl = 1'b0;
		regDst = ctrlPkg::rdRt;
		memToReg = ctrlPkg::mtrMdr;
		shiftControl = ctrlPkg::shNone;
		IorD = ctrlPkg::iodPc;
		shamtOrRs = 1'b0;

		case (step)
			ctrlPkg::stReset:
			begin
				irWrite = 1'b1;
				writeA = 1'b1;
				writeB = 1'b1;
				aluSrcA = 1'b1;
				aluSrcB = ctrlPkg::srcBImm;
				IorD = ctrlPkg::iodAluOut;
			end
			ctrlPkg::stFetch, ctrlPkg::stFetchWait, ctrlPkg::stIrWrite:
			begin
				irWrite = 1'b1;
				writeA = 1'b1;
				writeB = 1'b1;
				aluSrcB = ctrlPkg::srcBFour; // pc + 4
				aluControl = ctrlPkg::aluAdd;
				pcControl = (step == ctrlPkg::stIrWrite);
			end
			ctrlPkg::stDecode:
			begin
				writeA = 1'b1;
				writeB = 1'b1;
				aluSrcB = ctrlPkg::srcBImmShift; // precompute branch target
				aluControl = ctrlPkg::aluAdd;
				regAluControl = 1'b1;
				IorD = ctrlPkg::iodAluOut;
			end
			default:
			begin
				if (opClass != ctrlPkg::clsNop && opClass != ctrlPkg::clsBreak)
					IorD = ctrlPkg::iodAluOut;
				case (opClass)
					ctrlPkg::clsAluReg:
					begin
						aluSrcA = 1'b1;
						if (step == ctrlPkg::stExec0)
						begin
							aluControl = kindAluOp;
							regAluControl = 1'b1;
						end
						else
						begin
							aluSrcB = ctrlPkg::srcBImm;
							writeA = 1'b1;
							writeB = 1'b1;
							regDst = ctrlPkg::rdRd;
							regWrite = 1'b1;
							memToReg = ctrlPkg::mtrAluOut;
						end
					end
					ctrlPkg::clsBranchEq, ctrlPkg::clsBranchNe:
					begin
						pcCond = 1'b1;
						origPC = ctrlPkg::pcBranch;
						aluControl = ctrlPkg::aluSub; // zero flag compares rs and rt
						aluSrcA = 1'b1;
						bneORbeq = (opClass == ctrlPkg::clsBranchEq);
					end
					ctrlPkg::clsLoad, ctrlPkg::clsStore:
					begin
						aluControl = ctrlPkg::aluAdd; // base + offset
						aluSrcA = 1'b1;
						aluSrcB = ctrlPkg::srcBImm;
						writeA = 1'b1;
						regAluControl = (step == ctrlPkg::stExec0);
						if (opClass == ctrlPkg::clsLoad)
						begin
							mdrControl = (step == ctrlPkg::stExec3);
							regWrite = (step == ctrlPkg::stExec4);
						end
						else if (step == ctrlPkg::stExec1 || step == ctrlPkg::stExec2)
						begin
							memWriteOrRead = 1'b1;
							writeB = 1'b1;
						end
					end
					ctrlPkg::clsLui:
					begin
						memToReg = ctrlPkg::mtrImm;
						aluControl = ctrlPkg::aluAdd;
						writeA = 1'b1;
						writeB = 1'b1;
						regWrite = 1'b1;
					end
					ctrlPkg::clsJump, ctrlPkg::clsJumpReg:
					begin
						memToReg = ctrlPkg::mtrImm;
						aluControl = ctrlPkg::aluAdd;
						pcControl = 1'b1;
						writeA = (opClass == ctrlPkg::clsJumpReg);
						origPC = (opClass == ctrlPkg::clsJumpReg) ? ctrlPkg::pcReg : ctrlPkg::pcJump;
					end
					ctrlPkg::clsJal:
					begin
						origPC = ctrlPkg::pcJump;
						if (step == ctrlPkg::stExec0)
						begin
							memToReg = ctrlPkg::mtrPc; // link into ra
							regDst = ctrlPkg::rdRa;
							regWrite = 1'b1;
						end
						else
						begin
							memToReg = ctrlPkg::mtrImm;
							aluControl = ctrlPkg::aluAdd;
							pcControl = 1'b1;
						end
					end
					ctrlPkg::clsAluImm:
					begin
						aluSrcA = 1'b1;
						aluSrcB = ctrlPkg::srcBImm;
						if (step == ctrlPkg::stExec0)
						begin
							aluControl = kindAluOp;
							regAluControl = 1'b1;
						end
						else
						begin
							writeA = 1'b1;
							regWrite = 1'b1;
							memToReg = ctrlPkg::mtrAluOut;
						end
					end
					ctrlPkg::clsShift:
					begin
						aluControl = ctrlPkg::aluAdd;
						writeB = 1'b1;
						if (step == ctrlPkg::stExec0)
							shiftControl = ctrlPkg::shLoad;
						else
						begin
							memToReg = ctrlPkg::mtrShifter;
							regWrite = 1'b1;
							shamtOrRs = (opKind == ctrlPkg::skSllv || opKind == ctrlPkg::skSrav);
							case (opKind)
								ctrlPkg::skSll, ctrlPkg::skSllv: shiftControl = ctrlPkg::shLeft;
								ctrlPkg::skSra, ctrlPkg::skSrav: shiftControl = ctrlPkg::shRightArith;
								ctrlPkg::skSrl: shiftControl = ctrlPkg::shRightLogic;
								default: shiftControl = ctrlPkg::shNone;
							endcase
						end
					end
					ctrlPkg::clsSlt:
					begin
						aluControl = ctrlPkg::aluSlt;
						aluSrcA = 1'b1;
						writeA = 1'b1;
						writeB = 1'b1;
						if (step != ctrlPkg::stExec0)
						begin
							memToReg = menor ? ctrlPkg::mtrOne : ctrlPkg::mtrZero;
							regDst = ctrlPkg::rdRd;
							regWrite = 1'b1;
						end
					end
					default:
					begin
						memToReg = ctrlPkg::mtrAluOut; // nop, break, unknown
					end
				endcase
			end
		endcase
	end

endmodule

//--- design/controlUnit.sv
`timescale 1ns/10ps

module controlUnit
(
	input logic clk,
	input logic reset,
	input logic [ctrlPkg::opcodeWidth-1:0] opcode,
	input logic [ctrlPkg::functWidth-1:0] funct,
	input logic [ctrlPkg::shamtWidth-1:0] shamt,
	input logic menor,
	output logic memWriteOrRead,
	output logic mdrControl,
	output logic pcControl,
	output logic pcCond,
	output logic [ctrlPkg::origPCWidth-1:0] origPC,
	output logic bneORbeq,
	output logic irWrite,
	output logic writeA,
	output logic writeB,
	output logic regWrite,
	output logic aluSrcA,
	output logic [ctrlPkg::aluSrcBWidth-1:0] aluSrcB,
	output logic [ctrlPkg::aluControlWidth-1:0] aluControl,
	output logic regAluControl,
	output logic [ctrlPkg::regDstWidth-1:0] regDst,
	output logic [ctrlPkg::memToRegWidth-1:0] memToReg,
	output logic [ctrlPkg::shiftControlWidth-1:0] shiftControl,
	output logic [ctrlPkg::iorDWidth-1:0] IorD,
	output logic shamtOrRs
);

	logic [ctrlPkg::classWidth-1:0] opClass;
	logic [ctrlPkg::shiftKindWidth-1:0] opKind;
	logic [ctrlPkg::stepWidth-1:0] step;

	instrDecoder i_decoder
	(
		.opcode(opcode),
		.funct(funct),
		.shamt(shamt),
		.opClass(opClass),
		.opKind(opKind)
	);

	stepSequencer i_sequencer
	(
		.clk(clk),
		.reset(reset),
		.opClass(opClass),
		.step(step)
	);

	controlEncoder i_encoder
	(
		.opClass(opClass),
		.opKind(opKind),
		.step(step),
		.menor(menor),
		.memWriteOrRead(memWriteOrRead),
		.mdrControl(mdrControl),
		.pcControl(pcControl),
		.pcCond(pcCond),
		.origPC(origPC),
		.bneORbeq(bneORbeq),
		.irWrite(irWrite),
		.writeA(writeA),
		.writeB(writeB),
		.regWrite(regWrite),
		.aluSrcA(aluSrcA),
		.aluSrcB(aluSrcB),
		.aluControl(aluControl),
		.regAluControl(regAluControl),
		.regDst(regDst),
		.memToReg(memToReg),
		.shiftControl(shiftControl),
		.IorD(IorD),
		.shamtOrRs(shamtOrRs)
	);

endmodule

//--- verification/controlUnit_assert.sv
`timescale 1ns/10ps

module controlInvariants
(
	input logic clk,
	input logic reset,
	input logic memWriteOrRead,
	input logic regWrite,
	input logic pcCond,
	input logic [ctrlPkg::origPCWidth-1:0] origPC
);

	writeExclusive: assert property (@(posedge clk) disable iff (reset)
		!(memWriteOrRead && regWrite))
		else $error("memory write and register write are high together");

	branchTarget: assert property (@(posedge clk) disable iff (reset)
		pcCond |-> origPC == ctrlPkg::pcBranch)
		else $error("pcCond is high without the branch target selected");

	// first cycle out of reset is stReset
	quietAfterReset: assert property (@(posedge clk) $fell(reset) |-> !regWrite)
		else $error("regWrite is high in the cycle after reset falls");

endmodule

bind controlUnit controlInvariants i_invariants
(
	.clk(clk),
	.reset(reset),
	.memWriteOrRead(memWriteOrRead),
	.regWrite(regWrite),
	.pcCond(pcCond),
	.origPC(origPC)
);

//--- verification/controlUnitTb.sv
`timescale 1ns/10ps

module controlUnitTb;

	logic clk;
	logic reset;
	logic [ctrlPkg::opcodeWidth-1:0] opcode;
	logic [ctrlPkg::functWidth-1:0] funct;
	logic [ctrlPkg::shamtWidth-1:0] shamt;
	logic menor;
	logic memWriteOrRead;
	logic mdrControl;
	logic pcControl;
	logic pcCond;
	logic [ctrlPkg::origPCWidth-1:0] origPC;
	logic bneORbeq;
	logic irWrite;
	logic writeA;
	logic writeB;
	logic regWrite;
	logic aluSrcA;
	logic [ctrlPkg::aluSrcBWidth-1:0] aluSrcB;
	logic [ctrlPkg::aluControlWidth-1:0] aluControl;
	logic regAluControl;
	logic [ctrlPkg::regDstWidth-1:0] regDst;
	logic [ctrlPkg::memToRegWidth-1:0] memToReg;
	logic [ctrlPkg::shiftControlWidth-1:0] shiftControl;
	logic [ctrlPkg::iorDWidth-1:0] IorD;
	logic shamtOrRs;

	// reference model state
	logic [ctrlPkg::stepWidth-1:0] mStep;
	logic [ctrlPkg::stepWidth-1:0] checkedStep;
	logic [ctrlPkg::opcodeWidth-1:0] mOp;
	logic [ctrlPkg::functWidth-1:0] mFn;
	logic [ctrlPkg::shamtWidth-1:0] mSh;

	// predicted outputs and care flags for fields left open
	logic eIrWrite, ePcControl, ePcCond, eBneOrBeq, eRegWrite, eMemWrite, eMdr, eShamtOrRs;
	logic eWriteA, eWriteB, eAluSrcA, eRegAluControl;
	logic [ctrlPkg::origPCWidth-1:0] eOrigPC;
	logic [ctrlPkg::aluControlWidth-1:0] eAlu;
	logic [ctrlPkg::memToRegWidth-1:0] eMemToReg;
	logic [ctrlPkg::shiftControlWidth-1:0] eShift;
	logic [ctrlPkg::regDstWidth-1:0] eRegDst;
	logic [ctrlPkg::aluSrcBWidth-1:0] eAluSrcB;
	logic [ctrlPkg::iorDWidth-1:0] eIorD;
	bit careOrig, careRegDst, careMemToReg, careAlu;

	int unsigned lcgState;
	int checkCount;
	int errorCount;
	bit timedOut;

	controlUnit i_dut
	(
		.clk(clk),
		.reset(reset),
		.opcode(opcode),
		.funct(funct),
		.shamt(shamt),
		.menor(menor),
		.memWriteOrRead(memWriteOrRead),
		.mdrControl(mdrControl),
		.pcControl(pcControl),
		.pcCond(pcCond),
		.origPC(origPC),
		.bneORbeq(bneORbeq),
		.irWrite(irWrite),
		.writeA(writeA),
		.writeB(writeB),
		.regWrite(regWrite),
		.aluSrcA(aluSrcA),
		.aluSrcB(aluSrcB),
		.aluControl(aluControl),
		.regAluControl(regAluControl),
		.regDst(regDst),
		.memToReg(memToReg),
		.shiftControl(shiftControl),
		.IorD(IorD),
		.shamtOrRs(shamtOrRs)
	);

	always #2 clk = ~clk;

	function automatic int unsigned nextRand();
		lcgState = lcgState * 32'd1103515245 + 32'd12345;
		return lcgState >> 8;
	endfunction

	function automatic int execLength();
		case (mOp)
			ctrlPkg::opRType:
			begin
				case (mFn)
					ctrlPkg::fnAdd, ctrlPkg::fnAnd, ctrlPkg::fnSub, ctrlPkg::fnXor:
						return ctrlPkg::execLenAlu;
					ctrlPkg::fnSlt: return ctrlPkg::execLenSlt;
					ctrlPkg::fnJr: return ctrlPkg::execLenJump;
					ctrlPkg::fnSll: return (mSh != '0) ? ctrlPkg::execLenShift : ctrlPkg::execLenNop;
					ctrlPkg::fnSllv, ctrlPkg::fnSra, ctrlPkg::fnSrav, ctrlPkg::fnSrl:
						return ctrlPkg::execLenShift;
					default: return ctrlPkg::execLenNop; // break, unknown funct
				endcase
			end
			ctrlPkg::opBeq, ctrlPkg::opBne: return ctrlPkg::execLenBranch;
			ctrlPkg::opLw: return ctrlPkg::execLenLoad;
			ctrlPkg::opSw: return ctrlPkg::execLenStore;
			ctrlPkg::opLui: return ctrlPkg::execLenLui;
			ctrlPkg::opJ: return ctrlPkg::execLenJump;
			ctrlPkg::opJal: return ctrlPkg::execLenJal;
			ctrlPkg::opAddi, ctrlPkg::opAddiu, ctrlPkg::opAndi: return ctrlPkg::execLenAluImm;
			default: return ctrlPkg::execLenNop;
		endcase
	endfunction

	task automatic advanceModel();
		int n;
		n = int'(mStep) - int'(ctrlPkg::stExec0);
		case (mStep)
			ctrlPkg::stReset: mStep = ctrlPkg::stFetch;
			ctrlPkg::stFetch: mStep = ctrlPkg::stFetchWait;
			ctrlPkg::stFetchWait: mStep = ctrlPkg::stIrWrite;
			ctrlPkg::stIrWrite: mStep = ctrlPkg::stDecode;
			ctrlPkg::stDecode: mStep = ctrlPkg::stExec0;
			default:
			begin
				if (mOp == ctrlPkg::opRType && mFn == ctrlPkg::fnBreak)
					mStep = mStep; // halted
				else if (n + 1 >= execLength())
					mStep = ctrlPkg::stFetch;
				else
					mStep = mStep + 1'b1;
			end
		endcase
	endtask

	task automatic predict();
		int n;
		n = int'(mStep) - int'(ctrlPkg::stExec0);
		{eIrWrite, ePcControl, ePcCond, eBneOrBeq, eRegWrite, eMemWrite, eMdr, eShamtOrRs} = '0;
		{eWriteA, eWriteB, eAluSrcA, eRegAluControl} = '0;
		{careOrig, careRegDst, careMemToReg, careAlu} = '0;
		eOrigPC = ctrlPkg::pcSeq;
		eAlu = ctrlPkg::aluPass;
		eMemToReg = ctrlPkg::mtrAluOut;
		eShift = ctrlPkg::shNone;
		eRegDst = ctrlPkg::rdRt;
		eAluSrcB = ctrlPkg::srcBReg;
		eIorD = ctrlPkg::iodAluOut;
		case (mStep)
			ctrlPkg::stReset:
			begin
				eIrWrite = 1'b1;
				eWriteA = 1'b1;
				eWriteB = 1'b1;
				eAluSrcA = 1'b1;
				eAluSrcB = ctrlPkg::srcBImm;
			end
			ctrlPkg::stFetch, ctrlPkg::stFetchWait, ctrlPkg::stIrWrite:
			begin
				eIrWrite = 1'b1;
				eWriteA = 1'b1;
				eWriteB = 1'b1;
				eAluSrcB = ctrlPkg::srcBFour;
				eIorD = ctrlPkg::iodPc;
				if (mStep == ctrlPkg::stIrWrite)
				begin
					ePcControl = 1'b1; // pc + 4
					careOrig = 1'b1;
				end
			end
			ctrlPkg::stDecode:
			begin
				eWriteA = 1'b1;
				eWriteB = 1'b1;
				eRegAluControl = 1'b1;
				eAluSrcB = ctrlPkg::srcBImmShift;
			end
			default:
			begin
				case (mOp)
					ctrlPkg::opRType:
					begin
						case (mFn)
							ctrlPkg::fnAdd, ctrlPkg::fnAnd, ctrlPkg::fnSub, ctrlPkg::fnXor,
							ctrlPkg::fnSlt:
							begin
								eAluSrcA = 1'b1;
								eWriteA = (n != 0 || mFn == ctrlPkg::fnSlt);
								eWriteB = eWriteA;
								if (n == 0)
								begin
									careAlu = 1'b1;
									eRegAluControl = (mFn != ctrlPkg::fnSlt);
									case (mFn)
										ctrlPkg::fnAnd: eAlu = ctrlPkg::aluAnd;
										ctrlPkg::fnSub: eAlu = ctrlPkg::aluSub;
										ctrlPkg::fnXor: eAlu = ctrlPkg::aluXor;
										ctrlPkg::fnSlt: eAlu = ctrlPkg::aluSlt;
										default: eAlu = ctrlPkg::aluAdd;
									endcase
								end
								else
								begin
									eRegWrite = 1'b1;
									careRegDst = 1'b1;
									eRegDst = ctrlPkg::rdRd;
									careMemToReg = 1'b1;
									if (mFn == ctrlPkg::fnSlt)
										eMemToReg = menor ? ctrlPkg::mtrOne : ctrlPkg::mtrZero;
									else
										eAluSrcB = ctrlPkg::srcBImm;
								end
							end
							ctrlPkg::fnJr:
							begin
								ePcControl = 1'b1;
								careOrig = 1'b1;
								eOrigPC = ctrlPkg::pcReg;
								eWriteA = 1'b1;
							end
							ctrlPkg::fnSll, ctrlPkg::fnSllv, ctrlPkg::fnSra, ctrlPkg::fnSrav,
							ctrlPkg::fnSrl:
							begin
								if (mFn != ctrlPkg::fnSll || mSh != '0)
								begin
									eWriteB = 1'b1;
									if (n == 0)
										eShift = ctrlPkg::shLoad;
									else
									begin
										eRegWrite = 1'b1;
										careMemToReg = 1'b1;
										eMemToReg = ctrlPkg::mtrShifter;
										eShamtOrRs = (mFn == ctrlPkg::fnSllv || mFn == ctrlPkg::fnSrav);
										if (mFn == ctrlPkg::fnSll || mFn == ctrlPkg::fnSllv)
											eShift = ctrlPkg::shLeft;
										else if (mFn == ctrlPkg::fnSrl)
											eShift = ctrlPkg::shRightLogic;
										else
											eShift = ctrlPkg::shRightArith;
									end
								end
								else
									eIorD = ctrlPkg::iodPc; // sll with zero shamt is a nop
							end
							default: eIorD = ctrlPkg::iodPc; // break and unknown funct write nothing
						endcase
					end
					ctrlPkg::opBeq, ctrlPkg::opBne:
					begin
						ePcCond = 1'b1;
						careOrig = 1'b1;
						eOrigPC = ctrlPkg::pcBranch;
						eBneOrBeq = (mOp == ctrlPkg::opBeq);
						eAluSrcA = 1'b1;
					end
					ctrlPkg::opLw, ctrlPkg::opSw:
					begin
						eAluSrcA = 1'b1;
						eAluSrcB = ctrlPkg::srcBImm;
						eWriteA = 1'b1;
						eRegAluControl = (n == 0); // address add
						if (mOp == ctrlPkg::opLw)
						begin
							eMdr = (n == 3);
							if (n == 4)
							begin
								eRegWrite = 1'b1;
								careRegDst = 1'b1;
								careMemToReg = 1'b1;
								eMemToReg = ctrlPkg::mtrMdr;
							end
						end
						else
						begin
							eMemWrite = (n == 1 || n == 2);
							eWriteB = eMemWrite;
						end
					end
					ctrlPkg::opLui:
					begin
						eRegWrite = 1'b1;
						careMemToReg = 1'b1;
						eMemToReg = ctrlPkg::mtrImm;
						eWriteA = 1'b1;
						eWriteB = 1'b1;
					end
					ctrlPkg::opJ:
					begin
						ePcControl = 1'b1;
						careOrig = 1'b1;
						eOrigPC = ctrlPkg::pcJump;
					end
					ctrlPkg::opJal:
					begin
						if (n == 0)
						begin
							eRegWrite = 1'b1;
							careRegDst = 1'b1;
							eRegDst = ctrlPkg::rdRa;
							careMemToReg = 1'b1;
							eMemToReg = ctrlPkg::mtrPc;
						end
						else
						begin
							ePcControl = 1'b1;
							careOrig = 1'b1;
							eOrigPC = ctrlPkg::pcJump;
						end
					end
					ctrlPkg::opAddi, ctrlPkg::opAddiu, ctrlPkg::opAndi:
					begin
						eAluSrcA = 1'b1;
						eAluSrcB = ctrlPkg::srcBImm;
						if (n == 0)
						begin
							careAlu = 1'b1;
							eRegAluControl = 1'b1;
							eAlu = (mOp == ctrlPkg::opAndi) ? ctrlPkg::aluAnd : ctrlPkg::aluAdd;
						end
						else
						begin
							eRegWrite = 1'b1;
							careRegDst = 1'b1;
							careMemToReg = 1'b1;
							eWriteA = 1'b1;
						end
					end
					default: eIorD = ctrlPkg::iodPc;
				endcase
			end
		endcase
	endtask

	task automatic checkValue(input string name, input logic [7:0] expected,
		input logic [7:0] actual);
		checkCount++;
		if (actual !== expected)
		begin
			errorCount++;
			$display("mismatch at %0t ns: %s expected %0h actual %0h", $time, name, expected,
				actual);
		end
	endtask

	task automatic checkOutputs();
		predict();
		checkValue("irWrite", eIrWrite, irWrite);
		checkValue("pcControl", ePcControl, pcControl);
		checkValue("pcCond", ePcCond, pcCond);
		checkValue("bneORbeq", eBneOrBeq, bneORbeq);
		checkValue("regWrite", eRegWrite, regWrite);
		checkValue("memWriteOrRead", eMemWrite, memWriteOrRead);
		checkValue("mdrControl", eMdr, mdrControl);
		checkValue("shiftControl", eShift, shiftControl);
		checkValue("shamtOrRs", eShamtOrRs, shamtOrRs);
		checkValue("writeA", eWriteA, writeA);
		checkValue("writeB", eWriteB, writeB);
		checkValue("aluSrcA", eAluSrcA, aluSrcA);
		checkValue("aluSrcB", eAluSrcB, aluSrcB);
		checkValue("regAluControl", eRegAluControl, regAluControl);
		checkValue("IorD", eIorD, IorD);
		if (careOrig)
			checkValue("origPC", eOrigPC, origPC);
		if (careAlu)
			checkValue("aluControl", eAlu, aluControl);
		if (careRegDst)
			checkValue("regDst", eRegDst, regDst);
		if (careMemToReg)
			checkValue("memToReg", eMemToReg, memToReg);
	endtask

	// checks on the falling edge and then drives
	task automatic doCycle();
		@(negedge clk);
		checkedStep = mStep;
		checkOutputs();
		advanceModel();
		menor = 1'(nextRand() & 1);
	endtask

	task automatic applyInstr(input int index, input int unsigned r);
		logic [ctrlPkg::opcodeWidth-1:0] op;
		logic [ctrlPkg::functWidth-1:0] fn;
		logic [ctrlPkg::shamtWidth-1:0] sh;
		op = ctrlPkg::opRType;
		fn = r[13:8]; // immediate bits for I and J formats
		sh = r[4:0];
		case (index)
			0: fn = ctrlPkg::fnAdd;
			1: fn = ctrlPkg::fnAnd;
			2: fn = ctrlPkg::fnSub;
			3: fn = ctrlPkg::fnXor;
			4: fn = ctrlPkg::fnSlt;
			5:
			begin
				fn = ctrlPkg::fnSll; // nop
				sh = '0;
			end
			6: op = ctrlPkg::opBeq;
			7: op = ctrlPkg::opBne;
			8: op = ctrlPkg::opLw;
			9: op = ctrlPkg::opSw;
			10: op = ctrlPkg::opLui;
			11: op = ctrlPkg::opJ;
			12: fn = ctrlPkg::fnJr;
			13: op = ctrlPkg::opJal;
			14: op = ctrlPkg::opAddi;
			15: op = ctrlPkg::opAddiu;
			16: op = ctrlPkg::opAndi;
			17:
			begin
				fn = ctrlPkg::fnSll;
				sh = 5'(r % 31 + 1);
			end
			18: fn = ctrlPkg::fnSllv;
			19: fn = ctrlPkg::fnSra;
			20: fn = ctrlPkg::fnSrav;
			21: fn = ctrlPkg::fnSrl;
			22: fn = 6'h18; // mult is not supported
			default: fn = ctrlPkg::fnBreak;
		endcase
		opcode = op;
		funct = fn;
		shamt = sh;
		mOp = op;
		mFn = fn;
		mSh = sh;
	endtask

	// runs the current instruction, then loads a new one in its fetch cycle
	task automatic issue(input int index);
		int waited;
		waited = 0;
		doCycle();
		while (checkedStep != ctrlPkg::stFetch && waited < 16)
		begin
			doCycle();
			waited++;
		end
		if (checkedStep != ctrlPkg::stFetch)
		begin
			$display("timeout: the instruction did not return to fetch within 16 cycles");
			errorCount++;
			timedOut = 1'b1;
		end
		else
			applyInstr(index, nextRand());
	endtask

	task automatic doReset();
		reset = 1'b1;
		mStep = ctrlPkg::stReset;
		repeat (10)
		begin
			@(negedge clk);
			checkedStep = mStep;
			checkOutputs();
		end
		reset = 1'b0;
		mStep = ctrlPkg::stFetch; // stReset ends at the next rising edge
	endtask

	task automatic reportTest(input string name, input int checks, input int errors);
		$display("test %s: %0d checks, %0d errors", name, checks, errors);
	endtask

	initial
	begin
		int i;
		int startChecks;
		int startErrors;
		lcgState = 13;
		checkCount = 0;
		errorCount = 0;
		timedOut = 1'b0;
		clk = 1'b0;
		reset = 1'b1;
		menor = 1'b0;
		applyInstr(5, 0);
		doReset();

		startChecks = checkCount;
		startErrors = errorCount;
		for (i = 0; i < 23 && !timedOut; i++)
			issue(i);
		if (!timedOut)
			issue(5);
		reportTest("directed", checkCount - startChecks, errorCount - startErrors);

		startChecks = checkCount;
		startErrors = errorCount;
		for (i = 0; i < 80 && !timedOut; i++)
			issue(int'(nextRand() % 23)); // break is left out
		if (!timedOut)
			issue(5);
		reportTest("random", checkCount - startChecks, errorCount - startErrors);

		startChecks = checkCount;
		startErrors = errorCount;
		if (!timedOut)
		begin
			issue(23);
			repeat (24) doCycle(); // decode, then 20 and more halted cycles
			doReset();
			issue(5);
			issue(5);
		end
		reportTest("break halt", checkCount - startChecks, errorCount - startErrors);

		$display("tests 3, checks %0d, errors %0d", checkCount, errorCount);
		if (errorCount == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

//--- controlUnit.f
design/ctrlPkg.sv
design/instrDecoder.sv
design/stepSequencer.sv
design/controlEncoder.sv
design/controlUnit.sv
verification/controlUnit_assert.sv
verification/controlUnitTb.sv

//--- Bender.yml
package:
  name: controlUnit

sources:
  - design/ctrlPkg.sv
  - design/instrDecoder.sv
  - design/stepSequencer.sv
  - design/controlEncoder.sv
  - design/controlUnit.sv
  - target: test
    files:
      - verification/controlUnit_assert.sv
      - verification/controlUnitTb.sv
